// File: source/stencil_pkg.sv
// ---------------------------------------------------------------------
// stencil types for pixels, 3x3 windows, kernel modes and tap weights
// ---------------------------------------------------------------------
package stencil_pkg;

    typedef logic [7:0] pixel_t;

    // raster order with row 0 oldest and tap 4 at the centre
    typedef pixel_t [0:8] window_t;

    typedef enum logic {
        gauss = 1'b0,
        ident = 1'b1
    } kmode_t;

    typedef logic [11:0] acc_t;  // 255 * 16 fits

    localparam int NUM_TAPS   = 9;
    localparam int CENTER_TAP = 4;

    localparam acc_t gauss_coef [NUM_TAPS] = '{1, 2, 1, 2, 4, 2, 1, 2, 1};
    localparam int   gauss_shift = 4;  // weights sum to 16

endpackage

// File: source/cfg_pkg.sv
// ---------------------------------------------------------------------
// configuration register map and field types
// ---------------------------------------------------------------------
package cfg_pkg;

    typedef logic [1:0]  cfg_addr_t;
    typedef logic [15:0] cfg_word_t;

    localparam cfg_addr_t reg_width    = 2'd0;  // read/write row width
    localparam cfg_addr_t reg_mode     = 2'd1;  // read/write kernel mode
    localparam cfg_addr_t reg_mismatch = 2'd2;  // read only and cleared on write
    localparam cfg_addr_t reg_frames   = 2'd3;  // read only

    // narrowest row that still yields a full window
    localparam cfg_word_t MIN_WIDTH = 16'd3;

    localparam cfg_word_t CNT_MAX = 16'hffff;

endpackage

// File: source/stencil_cfg_regs.sv
// ---------------------------------------------------------------------
// stencil_cfg_regs holds row width and kernel mode
// and counts mismatches and finished frames
// ---------------------------------------------------------------------
module stencil_cfg_regs #(
    parameter int MAX_WIDTH = 16
) (
    input  logic                clk,
    input  logic                rst_init,
    input  logic                cfg_wr_valid,
    input  cfg_pkg::cfg_addr_t  cfg_addr,
    input  cfg_pkg::cfg_word_t  cfg_wdata,
    output logic                cfg_wr_ready,
    input  logic                cfg_rd_valid,
    output logic                cfg_rd_ready,
    output cfg_pkg::cfg_word_t  cfg_rdata,
    output logic                cfg_rdata_valid,
    input  logic                mismatch_inc,
    input  logic                frame_done,
    output logic [15:0]         row_width,
    output stencil_pkg::kmode_t kmode
);
    import cfg_pkg::*;
    import stencil_pkg::*;

    cfg_word_t mismatch_cnt;
    cfg_word_t frame_cnt;
    cfg_word_t width_clamped;
    logic      wr_en;

    assign cfg_wr_ready = 1'b1;
    assign cfg_rd_ready = 1'b1;
    assign wr_en        = cfg_wr_valid && cfg_wr_ready;

    always_comb begin
        width_clamped = cfg_wdata;
        if (cfg_wdata < MIN_WIDTH) begin
            width_clamped = MIN_WIDTH;
        end else if (cfg_wdata > cfg_word_t'(MAX_WIDTH)) begin
            width_clamped = cfg_word_t'(MAX_WIDTH);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            row_width       <= 16'(MAX_WIDTH);
            kmode           <= gauss;
            mismatch_cnt    <= '0;
            frame_cnt       <= '0;
            cfg_rdata_valid <= 1'b0;
        end else begin
            if (wr_en && cfg_addr == reg_width) begin
                row_width <= width_clamped;
            end
            if (wr_en && cfg_addr == reg_mode) begin
                kmode <= kmode_t'(cfg_wdata[0]);
            end
            if (wr_en && cfg_addr == reg_mismatch) begin
                mismatch_cnt <= '0;
            end else if (mismatch_inc && mismatch_cnt != CNT_MAX) begin
                mismatch_cnt <= mismatch_cnt + 16'd1;  // saturates
            end
            if (frame_done) begin
                frame_cnt <= frame_cnt + 16'd1;
            end
            cfg_rdata_valid <= cfg_rd_valid && cfg_rd_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_rd_valid && cfg_rd_ready) begin
            case (cfg_addr)
                reg_width:    cfg_rdata <= row_width;
                reg_mode:     cfg_rdata <= cfg_word_t'(kmode);
                reg_mismatch: cfg_rdata <= mismatch_cnt;
                reg_frames:   cfg_rdata <= frame_cnt;
            endcase
        end
    end

    a_width_range: assert property (@(posedge clk) disable iff (rst_init)
        row_width >= MIN_WIDTH && row_width <= 16'(MAX_WIDTH));

endmodule

// File: source/line_window.sv
// ---------------------------------------------------------------------
// line_window feeds a shifting 3x3 pixel window from two row buffers
// ---------------------------------------------------------------------
module line_window #(
    parameter int MAX_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 in_valid,
    input  stencil_pkg::pixel_t  in_data,
    input  logic                 in_last,
    output logic                 in_ready,
    input  logic [15:0]          row_width,
    output logic                 win_valid,
    output stencil_pkg::window_t win,
    input  logic                 win_ready,
    output logic                 frame_done
);
    import stencil_pkg::*;

    localparam int CW = $clog2(MAX_WIDTH);

    pixel_t          lb0 [MAX_WIDTH];  // row y-2
    pixel_t          lb1 [MAX_WIDTH];  // row y-1
    logic [CW-1:0]   col;
    logic [1:0]      rows;             // full rows seen up to 2
    logic            take;
    logic            col_wrap;

    assign in_ready = !win_valid || win_ready;
    assign take     = in_valid && in_ready;
    assign col_wrap = (16'(col) == row_width - 16'd1);

    always_ff @(posedge clk) begin
        if (rst_init) begin
            col        <= '0;
            rows       <= '0;
            win_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= take && in_last;
            if (take) begin
                win_valid <= (col >= 2) && (rows == 2'd2);
                if (in_last) begin
                    col  <= '0;
                    rows <= '0;
                end else if (col_wrap) begin
                    col <= '0;
                    if (rows != 2'd2) begin
                        rows <= rows + 2'd1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end else if (win_ready) begin
                win_valid <= 1'b0;
            end
        end
    end

    // line buffers and window shift
    always_ff @(posedge clk) begin
        if (take) begin
            lb0[col] <= lb1[col];
            lb1[col] <= in_data;
            for (int r = 0; r < 3; r++) begin
                win[3*r]   <= win[3*r+1];
                win[3*r+1] <= win[3*r+2];
            end
            win[2] <= lb0[col];
            win[5] <= lb1[col];
            win[8] <= in_data;
        end
    end

    a_col_range: assert property (@(posedge clk) disable iff (rst_init)
        16'(col) < row_width);

endmodule

// File: source/stencil_pipe.sv
// ---------------------------------------------------------------------
// stencil_pipe runs a two-stage 3x3 kernel that stalls as one unit
// ---------------------------------------------------------------------
module stencil_pipe (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 win_valid,
    input  stencil_pkg::window_t win,
    input  stencil_pkg::kmode_t  kmode,
    output logic                 win_ready,
    output logic                 res_valid,
    output stencil_pkg::pixel_t  res,
    input  logic                 res_ready
);
    import stencil_pkg::*;

    acc_t   row_sum [3];
    acc_t   s1_row  [3];
    pixel_t s1_ctr;
    kmode_t s1_mode;
    logic   s1_valid;
    acc_t   total;
    logic   advance;

    assign advance   = !res_valid || res_ready;
    assign win_ready = advance;
    assign total     = s1_row[0] + s1_row[1] + s1_row[2];

    // weighted sum per window row
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            row_sum[r] = '0;
            for (int k = 0; k < 3; k++) begin
                row_sum[r] = row_sum[r] + gauss_coef[3*r+k] * acc_t'(win[3*r+k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= win_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_row  <= row_sum;
            s1_ctr  <= win[CENTER_TAP];
            s1_mode <= kmode;  // mode travels with the item
            res     <= (s1_mode == ident) ? s1_ctr : pixel_t'(total >> gauss_shift);
        end
    end

endmodule

// File: source/stencil_step.sv
// ---------------------------------------------------------------------
// stencil_step adds one weighted tap per cycle into its accumulator
// ---------------------------------------------------------------------
module stencil_step (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 win_valid,
    input  stencil_pkg::window_t win,
    input  stencil_pkg::kmode_t  kmode,
    output logic                 win_ready,
    output logic                 res_valid,
    output stencil_pkg::pixel_t  res,
    input  logic                 res_ready
);
    import stencil_pkg::*;

    localparam logic [3:0] LAST_TAP = 4'(NUM_TAPS - 1);

    logic       busy;
    logic [3:0] tap;
    acc_t       acc;
    acc_t       acc_next;
    window_t    hold;
    kmode_t     mode_q;
    logic       start;

    // idle means nothing in progress and no result waiting
    assign win_ready = !busy && !res_valid;
    assign start     = win_valid && win_ready;
    assign acc_next  = acc + gauss_coef[tap] * acc_t'(hold[tap]);

    always_ff @(posedge clk) begin
        if (rst_init) begin
            busy      <= 1'b0;
            tap       <= '0;
            res_valid <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
                tap  <= '0;
            end else if (busy) begin
                if (tap == LAST_TAP) begin
                    busy      <= 1'b0;
                    res_valid <= 1'b1;
                end else begin
                    tap <= tap + 4'd1;
                end
            end
            if (res_valid && res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            hold   <= win;
            mode_q <= kmode;
            acc    <= '0;
        end else if (busy) begin
            acc <= acc_next;
            if (tap == LAST_TAP) begin
                res <= (mode_q == ident) ? hold[CENTER_TAP] : pixel_t'(acc_next >> gauss_shift);
            end
        end
    end

    a_tap_range: assert property (@(posedge clk) disable iff (rst_init)
        tap <= LAST_TAP);

endmodule

// File: source/eq_check.sv
// ---------------------------------------------------------------------
// eq_check pairs both kernel results, forwards one and flags a mismatch
// ---------------------------------------------------------------------
module eq_check (
    input  logic                clk,
    input  logic                rst_init,
    input  logic                pipe_valid,
    input  stencil_pkg::pixel_t pipe_res,
    output logic                pipe_ready,
    input  logic                step_valid,
    input  stencil_pkg::pixel_t step_res,
    output logic                step_ready,
    output logic                out_valid,
    output stencil_pkg::pixel_t out_data,
    output logic                out_mismatch,
    input  logic                out_ready,
    output logic                mismatch_inc
);
    import stencil_pkg::*;

    logic   p_full;
    logic   s_full;
    pixel_t p_val;
    pixel_t s_val;
    logic   out_take;

    assign pipe_ready   = !p_full;
    assign step_ready   = !s_full;
    assign out_take     = out_valid && out_ready;
    assign mismatch_inc = out_take && out_mismatch;

    always_ff @(posedge clk) begin
        if (rst_init) begin
            p_full    <= 1'b0;
            s_full    <= 1'b0;
            out_valid <= 1'b0;
        end else if (out_take) begin
            p_full    <= 1'b0;  // release both slots together
            s_full    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (pipe_valid && pipe_ready) begin
                p_full <= 1'b1;
            end
            if (step_valid && step_ready) begin
                s_full <= 1'b1;
            end
            if (p_full && s_full) begin
                out_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_valid && pipe_ready) begin
            p_val <= pipe_res;
        end
        if (step_valid && step_ready) begin
            s_val <= step_res;
        end
        if (p_full && s_full && !out_valid) begin
            out_data     <= p_val;
            out_mismatch <= (p_val != s_val);
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (rst_init)
        out_valid && !out_ready |=> $stable(out_data));

endmodule

// File: source/stencil_eq_top.sv
// ---------------------------------------------------------------------
// stencil_eq_top runs pipelined and step-wise stencils side by side
// ---------------------------------------------------------------------
module stencil_eq_top #(
    parameter int MAX_WIDTH = 16
) (
    input  logic                clk,
    input  logic                rst_init,
    input  logic                in_valid,
    output logic                in_ready,
    input  stencil_pkg::pixel_t in_data,
    input  logic                in_last,
    output logic                out_valid,
    input  logic                out_ready,
    output stencil_pkg::pixel_t out_data,
    output logic                out_mismatch,
    input  logic                cfg_wr_valid,
    output logic                cfg_wr_ready,
    input  cfg_pkg::cfg_addr_t  cfg_addr,
    input  cfg_pkg::cfg_word_t  cfg_wdata,
    input  logic                cfg_rd_valid,
    output logic                cfg_rd_ready,
    output cfg_pkg::cfg_word_t  cfg_rdata,
    output logic                cfg_rdata_valid
);
    import stencil_pkg::*;

    logic        pipe_in_ready;
    logic        step_in_ready;
    logic        in_take;
    logic [15:0] row_width;
    kmode_t      kmode;
    logic        mismatch_inc;
    logic        frame_done;
    logic        pw_valid;
    logic        pw_ready;
    window_t     pw;
    logic        sw_valid;
    logic        sw_ready;
    window_t     sw;
    logic        pr_valid;
    logic        pr_ready;
    pixel_t      pr;
    logic        sr_valid;
    logic        sr_ready;
    pixel_t      sr;

    // both windows must take each pixel on the same cycle
    assign in_ready = pipe_in_ready & step_in_ready;
    assign in_take  = in_valid & in_ready;

    stencil_cfg_regs #(.MAX_WIDTH(MAX_WIDTH)) cfg_i (
        .clk(clk), .rst_init(rst_init),
        .cfg_wr_valid(cfg_wr_valid), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .cfg_wr_ready(cfg_wr_ready), .cfg_rd_valid(cfg_rd_valid),
        .cfg_rd_ready(cfg_rd_ready), .cfg_rdata(cfg_rdata),
        .cfg_rdata_valid(cfg_rdata_valid), .mismatch_inc(mismatch_inc),
        .frame_done(frame_done), .row_width(row_width), .kmode(kmode)
    );

    line_window #(.MAX_WIDTH(MAX_WIDTH)) win_pipe_i (
        .clk(clk), .rst_init(rst_init),
        .in_valid(in_take), .in_data(in_data), .in_last(in_last),
        .in_ready(pipe_in_ready), .row_width(row_width),
        .win_valid(pw_valid), .win(pw), .win_ready(pw_ready),
        .frame_done(frame_done)
    );

    line_window #(.MAX_WIDTH(MAX_WIDTH)) win_step_i (
        .clk(clk), .rst_init(rst_init),
        .in_valid(in_take), .in_data(in_data), .in_last(in_last),
        .in_ready(step_in_ready), .row_width(row_width),
        .win_valid(sw_valid), .win(sw), .win_ready(sw_ready),
        .frame_done()
    );

    stencil_pipe pipe_i (
        .clk(clk), .rst_init(rst_init),
        .win_valid(pw_valid), .win(pw), .kmode(kmode), .win_ready(pw_ready),
        .res_valid(pr_valid), .res(pr), .res_ready(pr_ready)
    );

    stencil_step step_i (
        .clk(clk), .rst_init(rst_init),
        .win_valid(sw_valid), .win(sw), .kmode(kmode), .win_ready(sw_ready),
        .res_valid(sr_valid), .res(sr), .res_ready(sr_ready)
    );

    eq_check eq_i (
        .clk(clk), .rst_init(rst_init),
        .pipe_valid(pr_valid), .pipe_res(pr), .pipe_ready(pr_ready),
        .step_valid(sr_valid), .step_res(sr), .step_ready(sr_ready),
        .out_valid(out_valid), .out_data(out_data), .out_mismatch(out_mismatch),
        .out_ready(out_ready), .mismatch_inc(mismatch_inc)
    );

endmodule

// File: verif/stencil_eq_tb.sv
// ---------------------------------------------------------------------
// stencil_eq_tb streams table-driven frames through both stencil paths
// ---------------------------------------------------------------------
module stencil_eq_tb;
    import stencil_pkg::*;
    import cfg_pkg::*;

    localparam int MAX_W     = 16;
    localparam int NT        = 6;
    localparam int SRC_RAMP  = 0;
    localparam int SRC_CONST = 1;
    localparam int SRC_RAND  = 2;

    // one row per test
    // nonzero rows2 streams a second frame right after the first
    string  t_name  [NT] = '{"gauss_ramp", "ident_rand", "gauss_const",
                             "stall_rand", "ident_stall", "two_frames"};
    int     t_width [NT] = '{8, 10, 12, 16, 16, 9};
    int     t_rows  [NT] = '{4, 5, 4, 6, 4, 5};
    int     t_rows2 [NT] = '{0, 0, 0, 0, 0, 3};
    kmode_t t_mode  [NT] = '{gauss, ident, gauss, gauss, ident, gauss};
    int     t_src   [NT] = '{SRC_RAMP, SRC_RAND, SRC_CONST, SRC_RAND, SRC_RAND, SRC_RAND};
    int     t_duty  [NT] = '{100, 100, 100, 50, 30, 100};  // percent of cycles ready

    logic      clk, rst_init;
    logic      in_valid, in_ready, in_last;
    pixel_t    in_data;
    logic      out_valid, out_ready, out_mismatch;
    pixel_t    out_data;
    logic      cfg_wr_valid, cfg_wr_ready, cfg_rd_valid, cfg_rd_ready, cfg_rdata_valid;
    cfg_addr_t cfg_addr;
    cfg_word_t cfg_wdata, cfg_rdata;

    pixel_t img [MAX_W * 16];
    pixel_t exp_q [$];
    pixel_t got_q [$];
    logic   flag_q [$];
    int     errors = 0;
    int     checks = 0;
    int     frames_sent = 0;
    int     duty = 100;

    stencil_eq_top #(.MAX_WIDTH(MAX_W)) dut_i (
        .clk(clk), .rst_init(rst_init),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data), .in_last(in_last),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .out_mismatch(out_mismatch),
        .cfg_wr_valid(cfg_wr_valid), .cfg_wr_ready(cfg_wr_ready), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rd_valid(cfg_rd_valid), .cfg_rd_ready(cfg_rd_ready),
        .cfg_rdata(cfg_rdata), .cfg_rdata_valid(cfg_rdata_valid)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        #1;
        out_ready = (duty >= 100) || (int'($urandom_range(99)) < duty);
    end

    // sampled mid-cycle before the handshake edge
    always @(negedge clk) begin
        if (!rst_init && out_valid && out_ready) begin
            got_q.push_back(out_data);
            flag_q.push_back(out_mismatch);
        end
    end

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input cfg_word_t got, input cfg_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_word_t data);
        logic done;
        cfg_wr_valid = 1'b1;
        cfg_addr     = addr;
        cfg_wdata    = data;
        do begin
            @(negedge clk);
            done = cfg_wr_ready;
            @(posedge clk);
            #1;
        end while (!done);
        cfg_wr_valid = 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_t addr, output cfg_word_t data);
        logic done;
        int   waited;
        cfg_rd_valid = 1'b1;
        cfg_addr     = addr;
        do begin
            @(negedge clk);
            done = cfg_rd_ready;
            @(posedge clk);
            #1;
        end while (!done);
        cfg_rd_valid = 1'b0;
        done   = 1'b0;
        waited = 0;
        data   = '0;
        while (!done && waited < 8) begin
            @(negedge clk);
            if (cfg_rdata_valid) begin
                data = cfg_rdata;
                done = 1'b1;
            end
            waited++;
            @(posedge clk);
            #1;
        end
        if (!done) begin
            errors++;
            $display("ERROR: no read data came back for register %0d", addr);
        end
    endtask

    task automatic make_image(input int w, input int h, input int src);
        pixel_t c;
        c = pixel_t'($urandom);
        for (int i = 0; i < w * h; i++) begin
            case (src)
                SRC_RAMP:  img[i] = pixel_t'((i % w) * 9 + (i / w) * 23);
                SRC_CONST: img[i] = c;
                default:   img[i] = pixel_t'($urandom);
            endcase
        end
    endtask

    function automatic int tap_weight(input int d);
        return (d == 1) ? 2 : 1;  // 1-2-1 in each direction
    endfunction

    // reference stencil with one value per full window in raster order
    task automatic add_expected(input int w, input int h, input kmode_t m);
        int sum;
        for (int y = 2; y < h; y++) begin
            for (int x = 2; x < w; x++) begin
                sum = 0;
                for (int dy = 0; dy < 3; dy++) begin
                    for (int dx = 0; dx < 3; dx++) begin
                        sum += tap_weight(dy) * tap_weight(dx) * int'(img[(y-2+dy)*w + x-2+dx]);
                    end
                end
                if (m == ident) exp_q.push_back(img[(y-1)*w + x-1]);
                else exp_q.push_back(pixel_t'(sum >> 4));
            end
        end
    endtask

    task automatic send_frame(input int w, input int h);
        logic taken;
        for (int i = 0; i < w * h; i++) begin
            in_valid = 1'b1;
            in_data  = img[i];
            in_last  = (i == w * h - 1);
            do begin
                @(negedge clk);
                taken = in_ready;
                @(posedge clk);
                #1;
            end while (!taken);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic run_test(input int t);
        int        errs_before;
        int        waited;
        cfg_word_t rd;
        errs_before = errors;
        exp_q.delete();
        got_q.delete();
        flag_q.delete();
        duty = t_duty[t];
        write_reg(reg_width, cfg_word_t'(t_width[t]));
        write_reg(reg_mode, cfg_word_t'(t_mode[t]));
        make_image(t_width[t], t_rows[t], t_src[t]);
        add_expected(t_width[t], t_rows[t], t_mode[t]);
        send_frame(t_width[t], t_rows[t]);
        frames_sent++;
        if (t_rows2[t] > 0) begin  // no idle cycle between the frames
            make_image(t_width[t], t_rows2[t], t_src[t]);
            add_expected(t_width[t], t_rows2[t], t_mode[t]);
            send_frame(t_width[t], t_rows2[t]);
            frames_sent++;
        end
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < exp_q.size() * 40 + 100) begin
            @(posedge clk);
            waited++;
        end
        repeat (30) @(posedge clk);  // room for any extra output
        #1;
        if (got_q.size() != exp_q.size()) begin
            errors++;
            $display("ERROR: %s expected %0d outputs but received %0d",
                     t_name[t], exp_q.size(), got_q.size());
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_pixel("out_data", got_q[i], exp_q[i]);
            check_flag("out_mismatch", flag_q[i], 1'b0);
        end
        read_reg(reg_mismatch, rd);
        check_reg("reg_mismatch", rd, 16'd0);
        read_reg(reg_frames, rd);
        check_reg("reg_frames", rd, cfg_word_t'(frames_sent));
        $display("test %0d %s: %0d outputs, %0d errors",
                 t, t_name[t], got_q.size(), errors - errs_before);
    endtask

    initial begin
        int        total;
        total = 0;
        for (int t = 0; t < NT; t++) begin
            total += t_width[t] * (t_rows[t] + t_rows2[t]);
        end
        #((total * 40 + 200) * 8);
        $display("ERROR: watchdog expired after %0d cycles", total * 40 + 200);
        $display("Test failed");
        $finish;
    end

    initial begin
        cfg_word_t rd;
        int        errs_before;
        void'($urandom(371));
        clk          = 1'b0;
        rst_init     = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        in_last      = 1'b0;
        out_ready    = 1'b1;
        cfg_wr_valid = 1'b0;
        cfg_rd_valid = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        repeat (5) @(posedge clk);
        #1 rst_init = 1'b0;
        for (int t = 0; t < NT; t++) begin
            run_test(t);
        end
        errs_before = errors;
        write_reg(reg_width, 16'd40);  // above the line buffer size
        read_reg(reg_width, rd);
        check_reg("reg_width", rd, cfg_word_t'(MAX_W));
        $display("test %0d width_clamp: %0d errors", NT, errors - errs_before);
        $display("summary: %0d tests, %0d checks, %0d errors", NT + 1, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
source/stencil_pkg.sv
source/cfg_pkg.sv
source/stencil_cfg_regs.sv
source/line_window.sv
source/stencil_pipe.sv
source/stencil_step.sv
source/eq_check.sv
source/stencil_eq_top.sv
verif/stencil_eq_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the stencil testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module stencil_eq_tb -o stencil_sim \
    && ./obj_dir/stencil_sim > sim.log 2>&1
grep -q "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
